// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := cpu_tb
FILELIST := build.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
RUNARGS  := +verilator+error+limit+1000
SOURCES  := $(shell grep -v '^+' $(FILELIST)) source/cpu_settings.svh

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNARGS))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)

// ==== build.f ====
+incdir+source
source/cpu_pkg.sv
source/ctrl_if.sv
source/control.sv
source/fetch.sv
source/regFile.sv
source/alu.sv
source/dataMem.sv
source/cpu.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

// ==== source/alu.sv ====
// Combinational ALU with shifts, bit reverse, byte immediates and the compare flag
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu (
    ctrlIf.dp              ctl,
    input  cpu_pkg::word_t a,
    input  cpu_pkg::word_t b,
    output cpu_pkg::word_t result,
    output logic           cmpFlag
);
    localparam int SHW = $clog2(`CPU_DATA_W);

    logic [SHW-1:0]           shAmt;
    logic [2*`CPU_DATA_W-1:0] rolWide;
    logic [2*`CPU_DATA_W-1:0] rorWide;
    logic [`CPU_DATA_W:0]     sum;
    cpu_pkg::word_t           reversed;
    logic                     lessThan;
    logic                     equal;

    assign shAmt   = b[SHW-1:0];
    assign rolWide = {a, a} << shAmt;   // Upper half is the left rotate
    assign rorWide = {a, a} >> shAmt;   // Lower half is the right rotate
    assign sum     = {1'b0, a} + {1'b0, b};

    always_comb begin
        for (int i = 0; i < `CPU_DATA_W; i++) begin
            reversed[i] = a[`CPU_DATA_W-1-i];
        end
    end

    always_comb begin
        case (ctl.aluOp)
            cpu_pkg::ALU_SUB:  result = b - a;
            cpu_pkg::ALU_XOR:  result = a ^ b;
            cpu_pkg::ALU_ANDN: result = a & ~b;
            cpu_pkg::ALU_ROL:  result = rolWide[2*`CPU_DATA_W-1:`CPU_DATA_W];
            cpu_pkg::ALU_SLL:  result = a << shAmt;
            cpu_pkg::ALU_ROR:  result = rorWide[`CPU_DATA_W-1:0];
            cpu_pkg::ALU_SRL:  result = a >> shAmt;
            cpu_pkg::ALU_BTR:  result = reversed;
            cpu_pkg::ALU_LBI:  result = b;
            cpu_pkg::ALU_SLBI: result = (a << 8) | b;
            cpu_pkg::ALU_ADD:  result = sum[`CPU_DATA_W-1:0];
            default:           result = sum[`CPU_DATA_W-1:0];  // Compares
        endcase
    end

    assign equal    = (a == b);
    assign lessThan = ctl.aluSign ? ($signed(a) < $signed(b)) : (a < b);

    always_comb begin
        case (ctl.aluOp[1:0])
            2'b00:   cmpFlag = equal;             // SEQ
            2'b01:   cmpFlag = lessThan;          // SLT
            2'b10:   cmpFlag = lessThan | equal;  // SLE
            default: cmpFlag = sum[`CPU_DATA_W];  // SCO carry out
        endcase
    end

endmodule

// ==== source/control.sv ====
// Instruction decoder of the single-cycle core, turns the major opcode into the control bundle
`timescale 1ns/1ps

module control (
    input  cpu_pkg::word_t instr,
    ctrlIf.dec             ctl
);
    cpu_pkg::opcode_t op;

    assign op = instr[15:11];

    always_comb begin
        // Defaults describe a NOP
        ctl.regWrt  = 1'b0;
        ctl.regDst  = 2'd0;          // Rd of I-format 1
        ctl.regSrc  = 2'd2;          // ALU result
        ctl.bSrc    = 2'd0;          // Rt
        ctl.zeroExt = 1'b0;
        ctl.immSrc  = 1'b0;
        ctl.aluOp   = cpu_pkg::ALU_ADD;
        ctl.aluSign = 1'b0;
        ctl.aluJmp  = 1'b0;
        ctl.memWrt  = 1'b0;
        ctl.memRead = 1'b0;
        ctl.brKind  = cpu_pkg::BR_NONE;
        ctl.nHalt   = 1'b1;
        ctl.err     = 1'b0;

        case (op)
            cpu_pkg::OP_HALT: ctl.nHalt = 1'b0;
            cpu_pkg::OP_NOP: begin
            end
            cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI, cpu_pkg::OP_XORI, cpu_pkg::OP_ANDNI: begin
                ctl.regWrt  = 1'b1;
                ctl.bSrc    = 2'd1;
                ctl.zeroExt = op[1];     // XORI and ANDNI take an unsigned immediate
                ctl.aluOp   = cpu_pkg::ALU_ADD | cpu_pkg::aluOp_t'(op[1:0]);
            end
            cpu_pkg::OP_ROLI, cpu_pkg::OP_SLLI, cpu_pkg::OP_RORI, cpu_pkg::OP_SRLI: begin
                ctl.regWrt  = 1'b1;
                ctl.bSrc    = 2'd1;
                ctl.zeroExt = 1'b1;
                ctl.aluOp   = cpu_pkg::ALU_ROL | cpu_pkg::aluOp_t'(op[1:0]);
            end
            cpu_pkg::OP_ST: begin
                ctl.memWrt = 1'b1;
                ctl.bSrc   = 2'd1;       // Address is Rs + imm5
            end
            cpu_pkg::OP_LD: begin
                ctl.regWrt  = 1'b1;
                ctl.regSrc  = 2'd1;      // Memory
                ctl.memRead = 1'b1;
                ctl.bSrc    = 2'd1;
            end
            cpu_pkg::OP_STU: begin
                ctl.regWrt = 1'b1;
                ctl.regDst = 2'd1;       // Updated base back into Rs
                ctl.memWrt = 1'b1;
                ctl.bSrc   = 2'd1;
            end
            cpu_pkg::OP_BTR: begin
                ctl.regWrt = 1'b1;
                ctl.regDst = 2'd2;
                ctl.aluOp  = cpu_pkg::ALU_BTR;
            end
            cpu_pkg::OP_SHF, cpu_pkg::OP_ARI: begin
                ctl.regWrt = 1'b1;
                ctl.regDst = 2'd2;       // Rd of R-format
                ctl.aluOp  = (op[0] ? cpu_pkg::ALU_ADD : cpu_pkg::ALU_ROL)
                           | cpu_pkg::aluOp_t'(instr[1:0]);
            end
            cpu_pkg::OP_SEQ, cpu_pkg::OP_SLT, cpu_pkg::OP_SLE, cpu_pkg::OP_SCO: begin
                ctl.regWrt  = 1'b1;
                ctl.regDst  = 2'd2;
                ctl.regSrc  = 2'd3;      // Compare flag
                ctl.aluSign = 1'b1;
                ctl.aluOp   = cpu_pkg::ALU_CMP | cpu_pkg::aluOp_t'(op[1:0]);
            end
            cpu_pkg::OP_BEQZ, cpu_pkg::OP_BNEZ, cpu_pkg::OP_BLTZ, cpu_pkg::OP_BGEZ: begin
                ctl.immSrc = 1'b1;
                ctl.bSrc   = 2'd3;
                ctl.brKind = cpu_pkg::BR_COND | cpu_pkg::brKind_t'(op[1:0]);
            end
            cpu_pkg::OP_LBI: begin
                ctl.regWrt = 1'b1;
                ctl.regDst = 2'd1;
                ctl.bSrc   = 2'd2;       // Sign extended imm8
                ctl.aluOp  = cpu_pkg::ALU_LBI;
            end
            cpu_pkg::OP_SLBI: begin
                ctl.regWrt  = 1'b1;
                ctl.regDst  = 2'd1;
                ctl.bSrc    = 2'd2;
                ctl.zeroExt = 1'b1;
                ctl.aluOp   = cpu_pkg::ALU_SLBI;
            end
            cpu_pkg::OP_J: ctl.brKind = cpu_pkg::BR_JUMP;
            cpu_pkg::OP_JR: begin
                ctl.aluJmp = 1'b1;       // Target is Rs + imm8
                ctl.immSrc = 1'b1;
                ctl.bSrc   = 2'd2;
                ctl.brKind = cpu_pkg::BR_JUMP;
            end
            cpu_pkg::OP_JAL: begin
                ctl.regWrt = 1'b1;
                ctl.regDst = 2'd3;       // Link register R7
                ctl.regSrc = 2'd0;
                ctl.brKind = cpu_pkg::BR_JUMP;
            end
            cpu_pkg::OP_JALR: begin
                ctl.regWrt = 1'b1;
                ctl.regDst = 2'd3;
                ctl.regSrc = 2'd0;
                ctl.aluJmp = 1'b1;
                ctl.immSrc = 1'b1;
                ctl.bSrc   = 2'd2;
                ctl.brKind = cpu_pkg::BR_JUMP;
            end
            // siic, RTI and unused codes land here with all writes off
            default: ctl.err = 1'b1;
        endcase
    end

endmodule

// ==== source/cpu.sv ====
// Top level of the single-cycle core, wires the blocks and exports the retire trace
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    imemWrEn,
    input  logic [`CPU_IMEM_AW-1:0] imemAddr,
    input  cpu_pkg::word_t          imemWrData,
    output logic                    halted,
    output logic                    err,
    output logic                    wbEn,
    output cpu_pkg::regIdx_t        wbReg,
    output cpu_pkg::word_t          wbData
);
    ctrlIf ctl ();

    cpu_pkg::word_t instr;
    cpu_pkg::word_t pcPlus2;
    cpu_pkg::word_t rsVal;
    cpu_pkg::word_t rtVal;
    cpu_pkg::word_t aluB;
    cpu_pkg::word_t aluRes;
    cpu_pkg::word_t memData;
    logic           cmpFlag;

    control uDec (.instr(instr), .ctl(ctl.dec));

    fetch uFetch (
        .clk(clk), .rstN(rstN),
        .imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemWrData(imemWrData),
        .ctl(ctl.dp), .rsVal(rsVal), .aluRes(aluRes),
        .instr(instr), .pcPlus2(pcPlus2)
    );

    regFile uRf (
        .clk(clk), .rstN(rstN),
        .rdAddrA(instr[10:8]), .rdAddrB(instr[7:5]),   // Rs, and Rt or store data
        .wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData),
        .rdDataA(rsVal), .rdDataB(rtVal)
    );

    alu uAlu (.ctl(ctl.dp), .a(rsVal), .b(aluB), .result(aluRes), .cmpFlag(cmpFlag));

    dataMem uDm (
        .clk(clk), .wrEn(ctl.memWrt & ctl.nHalt), .rdEn(ctl.memRead),
        .addr(aluRes), .wrData(rtVal), .rdData(memData)
    );

    always_comb begin
        case (ctl.bSrc)
            2'd0:    aluB = rtVal;
            2'd1:    aluB = {{(`CPU_DATA_W-5){instr[4] & ~ctl.zeroExt}}, instr[4:0]};
            2'd2:    aluB = {{(`CPU_DATA_W-8){instr[7] & ~ctl.zeroExt}}, instr[7:0]};
            default: aluB = '0;
        endcase
    end

    always_comb begin
        case (ctl.regDst)
            2'd0:    wbReg = instr[7:5];
            2'd1:    wbReg = instr[10:8];
            2'd2:    wbReg = instr[4:2];
            default: wbReg = cpu_pkg::regIdx_t'(`CPU_REG_COUNT - 1);  // R7 link
        endcase
    end

    always_comb begin
        case (ctl.regSrc)
            2'd0:    wbData = pcPlus2;
            2'd1:    wbData = memData;
            2'd2:    wbData = aluRes;
            default: wbData = cpu_pkg::word_t'(cmpFlag);
        endcase
    end

    assign halted = ~ctl.nHalt;
    assign err    = ctl.err;
    assign wbEn   = ctl.regWrt & ctl.nHalt;  // Trace is the register write itself

endmodule

// ==== source/cpu_pkg.sv ====
// Shared types and opcode constants for the 16-bit core, referenced by scoped name
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0]            word_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIdx_t;
    typedef logic [4:0]                        opcode_t;
    typedef logic [4:0]                        aluOp_t;
    typedef logic [1:0]                        regDst_t;  // Rd(I1), Rs, Rd(R), R7
    typedef logic [1:0]                        regSrc_t;  // PC+2, memory, ALU, compare
    typedef logic [1:0]                        bSrc_t;    // Rt, imm5, imm8, zero
    typedef logic [3:0]                        brKind_t;  // Transfer, conditional, test

    // Major opcodes in instr[15:11]
    localparam opcode_t OP_HALT  = 5'b00000;
    localparam opcode_t OP_NOP   = 5'b00001;
    localparam opcode_t OP_J     = 5'b00100;
    localparam opcode_t OP_JR    = 5'b00101;
    localparam opcode_t OP_JAL   = 5'b00110;
    localparam opcode_t OP_JALR  = 5'b00111;
    localparam opcode_t OP_ADDI  = 5'b01000;
    localparam opcode_t OP_SUBI  = 5'b01001;
    localparam opcode_t OP_XORI  = 5'b01010;
    localparam opcode_t OP_ANDNI = 5'b01011;
    localparam opcode_t OP_BEQZ  = 5'b01100;
    localparam opcode_t OP_BNEZ  = 5'b01101;
    localparam opcode_t OP_BLTZ  = 5'b01110;
    localparam opcode_t OP_BGEZ  = 5'b01111;
    localparam opcode_t OP_ST    = 5'b10000;
    localparam opcode_t OP_LD    = 5'b10001;
    localparam opcode_t OP_SLBI  = 5'b10010;
    localparam opcode_t OP_STU   = 5'b10011;
    localparam opcode_t OP_ROLI  = 5'b10100;
    localparam opcode_t OP_SLLI  = 5'b10101;
    localparam opcode_t OP_RORI  = 5'b10110;
    localparam opcode_t OP_SRLI  = 5'b10111;
    localparam opcode_t OP_LBI   = 5'b11000;
    localparam opcode_t OP_BTR   = 5'b11001;
    localparam opcode_t OP_SHF   = 5'b11010;  // ROL, SLL, ROR, SRL by funct
    localparam opcode_t OP_ARI   = 5'b11011;  // ADD, SUB, XOR, ANDN by funct
    localparam opcode_t OP_SEQ   = 5'b11100;
    localparam opcode_t OP_SLT   = 5'b11101;
    localparam opcode_t OP_SLE   = 5'b11110;
    localparam opcode_t OP_SCO   = 5'b11111;

    // ALU operations, the low two bits follow the opcode or funct bits
    localparam aluOp_t ALU_ADD  = 5'b00000;
    localparam aluOp_t ALU_SUB  = 5'b00001;  // b - a
    localparam aluOp_t ALU_XOR  = 5'b00010;
    localparam aluOp_t ALU_ANDN = 5'b00011;
    localparam aluOp_t ALU_ROL  = 5'b00100;
    localparam aluOp_t ALU_SLL  = 5'b00101;
    localparam aluOp_t ALU_ROR  = 5'b00110;
    localparam aluOp_t ALU_SRL  = 5'b00111;
    localparam aluOp_t ALU_BTR  = 5'b01000;
    localparam aluOp_t ALU_LBI  = 5'b01001;
    localparam aluOp_t ALU_SLBI = 5'b01010;
    localparam aluOp_t ALU_CMP  = 5'b01100;  // Low bits pick SEQ, SLT, SLE, SCO

    localparam brKind_t BR_NONE = 4'b0000;
    localparam brKind_t BR_JUMP = 4'b1000;
    localparam brKind_t BR_COND = 4'b1100;  // Low bits pick EQZ, NEZ, LTZ, GEZ

endpackage

// ==== source/cpu_settings.svh ====
// Core widths and memory depths, included by the package and every RTL block that sizes storage
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and instruction width
`define CPU_DATA_W 16

// Architectural registers R0 to R7
`define CPU_REG_COUNT 8

// Instruction memory in words, indexed by PC bits [8:1]
`define CPU_IMEM_DEPTH 256
`define CPU_IMEM_AW 8

// Data memory in words, indexed by address bits [8:1]
`define CPU_DMEM_DEPTH 256
`define CPU_DMEM_AW 8

`endif

// ==== source/ctrl_if.sv ====
// Decoded control bundle, driven by the instruction decoder and read by the datapath blocks
`timescale 1ns/1ps

interface ctrlIf;
    logic              regWrt;
    cpu_pkg::regDst_t  regDst;
    cpu_pkg::regSrc_t  regSrc;
    cpu_pkg::bSrc_t    bSrc;
    logic              zeroExt;  // Immediate is zero extended
    logic              immSrc;   // PC offset from imm8, else disp11
    cpu_pkg::aluOp_t   aluOp;
    logic              aluSign;  // Signed compare
    logic              aluJmp;   // Jump target from ALU result
    logic              memWrt;
    logic              memRead;
    cpu_pkg::brKind_t  brKind;
    logic              nHalt;
    logic              err;

    modport dec (
        output regWrt, regDst, regSrc, bSrc, zeroExt, immSrc,
        output aluOp, aluSign, aluJmp, memWrt, memRead, brKind,
        output nHalt, err
    );

    modport dp (
        input regWrt, regDst, regSrc, bSrc, zeroExt, immSrc,
        input aluOp, aluSign, aluJmp, memWrt, memRead, brKind,
        input nHalt, err
    );
endinterface

// ==== source/dataMem.sv ====
// Word-addressed data memory with clocked write and combinational read
`timescale 1ns/1ps
`include "cpu_settings.svh"

module dataMem (
    input  logic           clk,
    input  logic           wrEn,
    input  logic           rdEn,
    input  cpu_pkg::word_t addr,
    input  cpu_pkg::word_t wrData,
    output cpu_pkg::word_t rdData
);
    cpu_pkg::word_t           mem [`CPU_DMEM_DEPTH];
    logic [`CPU_DMEM_AW-1:0]  idx;

    assign idx = addr[`CPU_DMEM_AW:1];  // Byte address, bit 0 dropped

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[idx] <= wrData;
        end
    end

    assign rdData = rdEn ? mem[idx] : '0;

endmodule

// ==== source/fetch.sv ====
// PC register, instruction memory with its reset-time load port, and next-PC selection
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    imemWrEn,
    input  logic [`CPU_IMEM_AW-1:0] imemAddr,
    input  cpu_pkg::word_t          imemWrData,
    ctrlIf.dp                       ctl,
    input  cpu_pkg::word_t          rsVal,
    input  cpu_pkg::word_t          aluRes,
    output cpu_pkg::word_t          instr,
    output cpu_pkg::word_t          pcPlus2
);
    cpu_pkg::word_t imem [`CPU_IMEM_DEPTH];
    cpu_pkg::word_t pc;
    cpu_pkg::word_t disp;
    cpu_pkg::word_t brTarget;
    cpu_pkg::word_t nextPc;
    logic           condMet;
    logic           taken;

    always_ff @(posedge clk) begin
        if (imemWrEn && !rstN) begin  // Program load only while in reset
            imem[imemAddr] <= imemWrData;
        end
    end

    assign instr   = imem[pc[`CPU_IMEM_AW:1]];  // Byte PC, word memory
    assign pcPlus2 = pc + cpu_pkg::word_t'(2);

    // Branches carry an 8-bit offset, J and JAL an 11-bit displacement
    assign disp = ctl.immSrc ? {{(`CPU_DATA_W-8){instr[7]}}, instr[7:0]}
                             : {{(`CPU_DATA_W-11){instr[10]}}, instr[10:0]};
    assign brTarget = pcPlus2 + disp;

    always_comb begin
        case (ctl.brKind[1:0])
            2'b00:   condMet = (rsVal == '0);          // BEQZ
            2'b01:   condMet = (rsVal != '0);          // BNEZ
            2'b10:   condMet = rsVal[`CPU_DATA_W-1];   // BLTZ
            default: condMet = ~rsVal[`CPU_DATA_W-1];  // BGEZ
        endcase
    end

    assign taken = ctl.brKind[3] & (~ctl.brKind[2] | condMet);

    always_comb begin
        if (!ctl.nHalt) begin
            nextPc = pc;                 // Sit on HALT
        end else if (!taken) begin
            nextPc = pcPlus2;
        end else if (ctl.aluJmp) begin
            nextPc = aluRes;
        end else begin
            nextPc = brTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== source/regFile.sv ====
// Eight-entry register file with two combinational read ports and one clocked write port
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  cpu_pkg::regIdx_t rdAddrA,
    input  cpu_pkg::regIdx_t rdAddrB,
    input  logic             wrEn,
    input  cpu_pkg::regIdx_t wrAddr,
    input  cpu_pkg::word_t   wrData,
    output cpu_pkg::word_t   rdDataA,
    output cpu_pkg::word_t   rdDataB
);
    cpu_pkg::word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // No bypass, a write is seen by reads after the edge
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

// ==== verif/cpu_checker.sv ====
// Concurrent checks on the core's status and retire trace, attached to the top level with bind
`timescale 1ns/1ps

module cpu_checker (
    input logic           clk,
    input logic           rstN,
    input logic           halted,
    input logic           err,
    input logic           wbEn,
    input cpu_pkg::word_t wbData
);
    int failCount = 0;  // Read by the testbench at the end

    // The PC sits on HALT, only reset can leave it
    haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
        else begin
            $error("halted dropped without a reset");
            failCount++;
        end

    noWriteWhenStopped: assert property (@(posedge clk) disable iff (!rstN)
        !(wbEn && (halted || err)))
        else begin
            $error("wbEn high while halted or on a decode error");
            failCount++;
        end

    wbDataKnown: assert property (@(posedge clk) disable iff (!rstN) wbEn |-> !$isunknown(wbData))
        else begin
            $error("wbData has unknown bits on a write-back");
            failCount++;
        end

endmodule

bind cpu cpu_checker uChk (
    .clk(clk), .rstN(rstN), .halted(halted), .err(err), .wbEn(wbEn), .wbData(wbData)
);

// ==== verif/cpu_input.mem ====
// Each record is tag, register and word: 1 = program word, E = expected write-back
// (register in the second digit), C = count of expected write-backs, ends the file
10C185 109134 10C212 10427D 104A85 1051BF 1059D4 10A1C4
10A9C3 10B1C8 10B9CC 10DA78 10DA79 10D99A 10D95B 10D178
10D159 10D55A 10D15B 10C918 1082A4 108AE4 109A22 108AC0
10E620 10E940 10F220 10F9A0 106002 106802 10C3EE 107102
10C3EE 107902 102002 10C3EE 103002 10C3EE 103F06 10C3EE
102F06 10C3EE 100800 104361 100000
// Byte immediates, I-format ALU, shift immediates
E1FF85 E18534 E20012 E3000F E4FFF3 E5852B E68520 E65348
E629A0 E63485 E60008
// R-format, BTR, memory, compares
E60021 E6FFFD E67AC7 E68524 E6429A E614D0 E6E14A E6214D
E62CA1 E7852B E20014 E68534 E00001 E00001 E00000 E00001
// Links from JAL and JALR, then the add after the last jump
E7004A E7004E E30010
C0001E

// ==== verif/cpu_tb.sv ====
// Testbench for the core, loads the program from the data file, runs it and checks the trace
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;
    logic                    clk;
    logic                    rstN;
    logic                    imemWrEn;
    logic [`CPU_IMEM_AW-1:0] imemAddr;
    cpu_pkg::word_t          imemWrData;
    logic                    halted;
    logic                    err;
    logic                    wbEn;
    cpu_pkg::regIdx_t        wbReg;
    cpu_pkg::word_t          wbData;

    logic [23:0]    recs [128];  // Tag, register, word
    cpu_pkg::word_t prog [$];
    logic [19:0]    expWb [$];   // Register and value per write-back
    int             expCount = -1;
    int             expIdx = 0;
    int             cycles = 0;
    int             limit;
    int             valErrs = 0;
    int             otherErrs = 0;
    int             ckErrs;
    bit             errSeen = 1'b0;

    cpu UUT (.*);

    always #4 clk = ~clk;

    task automatic checkWrite();
        logic [19:0] rec;
        if (expIdx >= expWb.size()) begin
            $display("Unexpected write-back to R%0d after the last expected one", wbReg);
            otherErrs++;
        end else begin
            rec = expWb[expIdx];
            assert (wbReg == rec[18:16]) else begin
                $display("Fail wbReg: got %h, expected %h (write %0d)", wbReg, rec[18:16], expIdx);
                valErrs++;
            end
            assert (wbData == rec[15:0]) else begin
                $display("Fail wbData: got %h, expected %h (write %0d)", wbData, rec[15:0], expIdx);
                valErrs++;
            end
        end
        expIdx++;
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        imemWrEn   = 1'b0;
        imemAddr   = '0;
        imemWrData = '0;
        $readmemh("verif/cpu_input.mem", recs);
        for (int i = 0; i < 128 && expCount < 0; i++) begin
            case (recs[i][23:20])
                4'h1: prog.push_back(recs[i][15:0]);
                4'hE: expWb.push_back(recs[i][19:0]);
                4'hC: expCount = int'(recs[i][15:0]);  // End of file
                default: begin
                    $display("Record %0d of the data file has an unknown tag", i);
                    otherErrs++;
                    expCount = 0;
                end
            endcase
        end
        if (expCount != expWb.size()) begin
            $display("Data file holds %0d write-backs, its count says %0d", expWb.size(), expCount);
            otherErrs++;
        end

        foreach (prog[i]) begin
            @(posedge clk);
            imemWrEn   <= 1'b1;
            imemAddr   <= i[`CPU_IMEM_AW-1:0];
            imemWrData <= prog[i];
        end
        @(posedge clk);
        imemWrEn <= 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        // One instruction per cycle, trace sampled mid-cycle
        limit = prog.size() * 4 + 50;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (err && !errSeen) begin
                $display("Decode error raised in cycle %0d", cycles);
                errSeen = 1'b1;
                otherErrs++;
            end
            if (wbEn) begin
                checkWrite();
            end
        end

        if (!halted) begin
            $display("Timeout after %0d cycles without reaching HALT", cycles);
            otherErrs++;
        end else begin
            repeat (3) @(negedge clk);
            assert (halted) else begin
                $display("halted fell while the core sat on HALT");
                otherErrs++;
            end
        end
        assert (expIdx == expCount) else begin
            $display("Saw %0d write-backs where %0d were expected", expIdx, expCount);
            otherErrs++;
        end

        ckErrs = UUT.uChk.failCount;
        $display("Errors: %0d value, %0d other, %0d checker", valErrs, otherErrs, ckErrs);
        if (valErrs + otherErrs + ckErrs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
